// File: common/mipsPkg.sv
`default_nettype none

package mipsPkg;
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 32;
	localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

	// Opcodes
	localparam logic [5:0] opRType = 6'd0;
	localparam logic [5:0] opJ = 6'd2;
	localparam logic [5:0] opJal = 6'd3;
	localparam logic [5:0] opBeq = 6'd4;
	localparam logic [5:0] opBne = 6'd5;
	localparam logic [5:0] opAddiu = 6'd9;
	localparam logic [5:0] opSlti = 6'd10;
	localparam logic [5:0] opAndi = 6'd12;
	localparam logic [5:0] opOri = 6'd13;
	localparam logic [5:0] opXori = 6'd14;
	localparam logic [5:0] opLui = 6'd15;
	localparam logic [5:0] opLw = 6'd35;
	localparam logic [5:0] opSw = 6'd43;

	// R-type funct field
	localparam logic [5:0] fnAddu = 6'd33;
	localparam logic [5:0] fnSubu = 6'd35;
	localparam logic [5:0] fnAnd = 6'd36;
	localparam logic [5:0] fnOr = 6'd37;
	localparam logic [5:0] fnXor = 6'd38;
	localparam logic [5:0] fnNor = 6'd39;
	localparam logic [5:0] fnSlt = 6'd42;
	localparam logic [5:0] fnSltu = 6'd43;

	localparam logic [1:0] wbAlu = 2'd0; // memToReg choices
	localparam logic [1:0] wbMem = 2'd1;
	localparam logic [1:0] wbLink = 2'd2;

	localparam logic [1:0] destRt = 2'd0; // destSel choices
	localparam logic [1:0] destRd = 2'd1;
	localparam logic [1:0] destLink = 2'd2;

	typedef enum logic [3:0] {
		aluAnd,
		aluOr,
		aluAdd,
		aluSub,
		aluSlt,
		aluSltu,
		aluXor,
		aluNor,
		aluLui
	} aluOpT;

	typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSelT;

	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rt;
			logic [regAddrWidth-1:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0] opcode;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rt;
			logic [15:0] imm16;
		} iType;
		struct packed {
			logic [5:0] opcode;
			logic [25:0] target26;
		} jType;
	} instrWordT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic [1:0] memToReg;
		logic aluSrcImm;
		logic signExt;
		aluOpT aluOp;
		logic branchEq;
		logic branchNe;
		logic jump;
		logic [1:0] destSel;
	} ctrlT;

	typedef struct packed {
		instrWordT instr;
		logic [dataWidth-1:0] pc;
		logic [dataWidth-1:0] pcPlus4;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		logic [dataWidth-1:0] rsData;
		logic [dataWidth-1:0] rtData;
		logic [dataWidth-1:0] imm;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] dest;
		logic [dataWidth-1:0] pcPlus4;
		logic [dataWidth-1:0] branchTarget;
	} idExT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic [1:0] memToReg;
		logic [dataWidth-1:0] aluResult;
		logic [dataWidth-1:0] storeData;
		logic [regAddrWidth-1:0] dest;
		logic [dataWidth-1:0] pcPlus4;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic [1:0] memToReg;
		logic [dataWidth-1:0] aluResult;
		logic [dataWidth-1:0] memData;
		logic [regAddrWidth-1:0] dest;
		logic [dataWidth-1:0] pcPlus4;
	} memWbT;
endpackage

`default_nettype wire

// File: decode/controlDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module controlDecoder (
	input wire mipsPkg::instrWordT instr,
	output mipsPkg::ctrlT ctrl
);

	always_comb begin
		ctrl = '0; // Inactive unless a kept opcode matches
		case (instr.rType.opcode)
			mipsPkg::opRType: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = mipsPkg::destRd;
				case (instr.rType.funct)
					mipsPkg::fnAddu: ctrl.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSubu: ctrl.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: ctrl.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr: ctrl.aluOp = mipsPkg::aluOr;
					mipsPkg::fnXor: ctrl.aluOp = mipsPkg::aluXor;
					mipsPkg::fnNor: ctrl.aluOp = mipsPkg::aluNor;
					mipsPkg::fnSlt: ctrl.aluOp = mipsPkg::aluSlt;
					mipsPkg::fnSltu: ctrl.aluOp = mipsPkg::aluSltu;
					default: ctrl = '0; // Also covers the all-zero word
				endcase
			end
			mipsPkg::opAddiu: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.aluOp = mipsPkg::aluAdd;
			end
			mipsPkg::opSlti: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.aluOp = mipsPkg::aluSlt;
			end
			mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1; // Zero-extended
				case (instr.iType.opcode)
					mipsPkg::opAndi: ctrl.aluOp = mipsPkg::aluAnd;
					mipsPkg::opOri: ctrl.aluOp = mipsPkg::aluOr;
					mipsPkg::opXori: ctrl.aluOp = mipsPkg::aluXor;
					default: ctrl.aluOp = mipsPkg::aluLui;
				endcase
			end
			mipsPkg::opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = mipsPkg::wbMem;
				ctrl.aluSrcImm = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.aluOp = mipsPkg::aluAdd;
			end
			mipsPkg::opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.aluOp = mipsPkg::aluAdd;
			end
			mipsPkg::opBeq, mipsPkg::opBne: begin
				ctrl.signExt = 1'b1; // Word offset for the target
				ctrl.aluOp = mipsPkg::aluSub;
				ctrl.branchEq = (instr.iType.opcode == mipsPkg::opBeq);
				ctrl.branchNe = (instr.iType.opcode == mipsPkg::opBne);
			end
			mipsPkg::opJ: ctrl.jump = 1'b1;
			mipsPkg::opJal: begin
				ctrl.jump = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = mipsPkg::wbLink;
				ctrl.destSel = mipsPkg::destLink;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: decode/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input wire logic Clk,
	input wire logic [mipsPkg::regAddrWidth-1:0] rs,
	input wire logic [mipsPkg::regAddrWidth-1:0] rt,
	input wire logic [mipsPkg::regAddrWidth-1:0] wrAddr,
	input wire logic [mipsPkg::dataWidth-1:0] wrData,
	input wire logic wrEn,
	output logic [mipsPkg::dataWidth-1:0] rsData,
	output logic [mipsPkg::dataWidth-1:0] rtData
);

	logic [mipsPkg::dataWidth-1:0] regs [mipsPkg::regCount];
	logic wrActive;

	assign wrActive = wrEn && (wrAddr != '0);

	always_ff @(posedge Clk) begin
		if (wrActive)
			regs[wrAddr] <= wrData;
	end

	// Writeback value seen by decode in the same cycle
	assign rsData = (rs == '0) ? '0 :
		(wrActive && wrAddr == rs) ? wrData : regs[rs];
	assign rtData = (rt == '0) ? '0 :
		(wrActive && wrAddr == rt) ? wrData : regs[rt];

endmodule

`default_nettype wire

// File: filelist.f
+incdir+sim
common/mipsPkg.sv
decode/controlDecoder.sv
decode/registerFile.sv
logic/aluUnit.sv
logic/hazardUnit.sv
logic/mipsPipeline.sv
sim/tbMipsPipeline.sv

// File: logic/aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
	input wire mipsPkg::aluOpT op,
	input wire logic [mipsPkg::dataWidth-1:0] a,
	input wire logic [mipsPkg::dataWidth-1:0] b,
	output logic [mipsPkg::dataWidth-1:0] result,
	output logic zero
);

	localparam int padWidth = mipsPkg::dataWidth - 1;

	always_comb begin
		case (op)
			mipsPkg::aluAnd: result = a & b;
			mipsPkg::aluOr: result = a | b;
			mipsPkg::aluAdd: result = a + b;
			mipsPkg::aluSub: result = a - b;
			mipsPkg::aluSlt: result = {{padWidth{1'b0}}, $signed(a) < $signed(b)};
			mipsPkg::aluSltu: result = {{padWidth{1'b0}}, a < b};
			mipsPkg::aluXor: result = a ^ b;
			mipsPkg::aluNor: result = ~(a | b);
			mipsPkg::aluLui: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0); // Equal operands under aluSub

endmodule

`default_nettype wire

// File: logic/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
	input wire logic [mipsPkg::regAddrWidth-1:0] idRs,
	input wire logic [mipsPkg::regAddrWidth-1:0] idRt,
	input wire logic [mipsPkg::regAddrWidth-1:0] exRs,
	input wire logic [mipsPkg::regAddrWidth-1:0] exRt,
	input wire logic [mipsPkg::regAddrWidth-1:0] exDest,
	input wire logic exMemRead,
	input wire logic [mipsPkg::regAddrWidth-1:0] memDest,
	input wire logic memRegWrite,
	input wire logic [mipsPkg::regAddrWidth-1:0] wbDest,
	input wire logic wbRegWrite,
	output mipsPkg::fwdSelT fwdA,
	output mipsPkg::fwdSelT fwdB,
	output logic stall
);

	// Youngest producer wins
	function automatic mipsPkg::fwdSelT pickFwd(
		input logic [mipsPkg::regAddrWidth-1:0] src,
		input logic [mipsPkg::regAddrWidth-1:0] mDest,
		input logic mWrite,
		input logic [mipsPkg::regAddrWidth-1:0] wDest,
		input logic wWrite
	);
		if (src == '0)
			return mipsPkg::fwdNone;
		if (mWrite && mDest == src)
			return mipsPkg::fwdMem;
		if (wWrite && wDest == src)
			return mipsPkg::fwdWb;
		return mipsPkg::fwdNone;
	endfunction

	assign fwdA = pickFwd(exRs, memDest, memRegWrite, wbDest, wbRegWrite);
	assign fwdB = pickFwd(exRt, memDest, memRegWrite, wbDest, wbRegWrite);

	// Load data is not ready until the memory stage
	assign stall = exMemRead && (exDest != '0) &&
		(exDest == idRs || exDest == idRt);

endmodule

`default_nettype wire

// File: logic/mipsPipeline.sv
`timescale 1ns/1ns
`default_nettype none

module mipsPipeline #(
	parameter logic [31:0] resetVector = 32'h0000_0000
) (
	input wire logic Clk,
	input wire logic rstN,
	output logic [mipsPkg::dataWidth-1:0] instrAddr,
	input wire mipsPkg::instrWordT instr,
	output logic [mipsPkg::dataWidth-1:0] memAddr,
	output logic [mipsPkg::dataWidth-1:0] memWrData,
	output logic memWrite,
	output logic memRead,
	input wire logic [mipsPkg::dataWidth-1:0] memRdData
);

	mipsPkg::ifIdT ifId, ifIdNext;
	mipsPkg::idExT idEx, idExNext;
	mipsPkg::exMemT exMem, exMemNext;
	mipsPkg::memWbT memWb, memWbNext;
	mipsPkg::ctrlT idCtrl;
	mipsPkg::fwdSelT fwdA, fwdB;
	logic [mipsPkg::dataWidth-1:0] rsData, rtData, idImm, jumpTarget;
	logic [mipsPkg::dataWidth-1:0] opA, rtFwd, opB, aluResult, memResult, wbData;
	logic [mipsPkg::regAddrWidth-1:0] idDest;
	logic aluZero, stall, branchTaken;

	function automatic logic [mipsPkg::dataWidth-1:0] pickResult(
		input logic [1:0] sel,
		input logic [mipsPkg::dataWidth-1:0] aluVal,
		input logic [mipsPkg::dataWidth-1:0] memVal,
		input logic [mipsPkg::dataWidth-1:0] linkVal
	);
		case (sel)
			mipsPkg::wbMem: return memVal;
			mipsPkg::wbLink: return linkVal;
			default: return aluVal;
		endcase
	endfunction

	function automatic logic [mipsPkg::dataWidth-1:0] fwdMux(
		input mipsPkg::fwdSelT sel,
		input logic [mipsPkg::dataWidth-1:0] regVal,
		input logic [mipsPkg::dataWidth-1:0] memVal,
		input logic [mipsPkg::dataWidth-1:0] wbVal
	);
		case (sel)
			mipsPkg::fwdMem: return memVal;
			mipsPkg::fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign ifIdNext = '{instr: instr, pc: instrAddr, pcPlus4: instrAddr + 32'd4};

	controlDecoder ctrlDec (.instr(ifId.instr), .ctrl(idCtrl));

	registerFile regFile (
		.Clk(Clk),
		.rs(ifId.instr.rType.rs),
		.rt(ifId.instr.rType.rt),
		.wrAddr(memWb.dest),
		.wrData(wbData),
		.wrEn(memWb.regWrite),
		.rsData(rsData),
		.rtData(rtData)
	);

	assign idImm = idCtrl.signExt ?
		{{16{ifId.instr.iType.imm16[15]}}, ifId.instr.iType.imm16} :
		{16'h0000, ifId.instr.iType.imm16};
	assign jumpTarget = {ifId.pcPlus4[31:28], ifId.instr.jType.target26, 2'b00};

	always_comb begin
		case (idCtrl.destSel)
			mipsPkg::destRd: idDest = ifId.instr.rType.rd;
			mipsPkg::destLink: idDest = mipsPkg::linkReg;
			default: idDest = ifId.instr.rType.rt;
		endcase
	end

	assign idExNext = '{
		ctrl: idCtrl,
		rsData: rsData,
		rtData: rtData,
		imm: idImm,
		rs: ifId.instr.rType.rs,
		rt: ifId.instr.rType.rt,
		dest: idDest,
		pcPlus4: ifId.pcPlus4,
		branchTarget: ifId.pcPlus4 + {idImm[29:0], 2'b00}
	};

	hazardUnit hazard (
		.idRs(ifId.instr.rType.rs),
		.idRt(ifId.instr.rType.rt),
		.exRs(idEx.rs),
		.exRt(idEx.rt),
		.exDest(idEx.dest),
		.exMemRead(idEx.ctrl.memRead),
		.memDest(exMem.dest),
		.memRegWrite(exMem.regWrite),
		.wbDest(memWb.dest),
		.wbRegWrite(memWb.regWrite),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.stall(stall)
	);

	assign opA = fwdMux(fwdA, idEx.rsData, memResult, wbData);
	assign rtFwd = fwdMux(fwdB, idEx.rtData, memResult, wbData);
	assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : rtFwd;

	aluUnit alu (.op(idEx.ctrl.aluOp), .a(opA), .b(opB), .result(aluResult), .zero(aluZero));

	// Predicted not taken so only a taken branch redirects
	assign branchTaken = (idEx.ctrl.branchEq & aluZero) | (idEx.ctrl.branchNe & ~aluZero);

	assign exMemNext = '{
		regWrite: idEx.ctrl.regWrite,
		memRead: idEx.ctrl.memRead,
		memWrite: idEx.ctrl.memWrite,
		memToReg: idEx.ctrl.memToReg,
		aluResult: aluResult,
		storeData: rtFwd,
		dest: idEx.dest,
		pcPlus4: idEx.pcPlus4
	};

	assign memAddr = exMem.aluResult;
	assign memWrData = exMem.storeData;
	assign memWrite = exMem.memWrite;
	assign memRead = exMem.memRead;
	assign memResult = pickResult(exMem.memToReg, exMem.aluResult, memRdData, exMem.pcPlus4);

	assign memWbNext = '{
		regWrite: exMem.regWrite,
		memToReg: exMem.memToReg,
		aluResult: exMem.aluResult,
		memData: memRdData,
		dest: exMem.dest,
		pcPlus4: exMem.pcPlus4
	};

	assign wbData = pickResult(memWb.memToReg, memWb.aluResult, memWb.memData, memWb.pcPlus4);

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			instrAddr <= resetVector;
			ifId <= '0; // Zero word decodes as a no-op
			idEx <= '0;
			exMem <= '0;
			memWb <= '0;
		end else begin
			exMem <= exMemNext;
			memWb <= memWbNext;
			if (branchTaken) begin
				instrAddr <= idEx.branchTarget;
				ifId <= '0;
				idEx <= '0;
			end else if (stall) begin
				idEx <= '0; // Bubble while PC and IF/ID hold
			end else if (idCtrl.jump) begin
				instrAddr <= jumpTarget;
				ifId <= '0;
				idEx <= idExNext;
			end else begin
				instrAddr <= ifIdNext.pcPlus4;
				ifId <= ifIdNext;
				idEx <= idExNext;
			end
		end
	end

endmodule

`default_nettype wire

// File: runSim.sh
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator, run it and scan the log
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log
failText="Regression failed"

if ! verilator --binary --timing --assert --top-module tbMipsPipeline \
	--Mdir "$buildDir" -f filelist.f; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/VtbMipsPipeline" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if [ "$runStatus" -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -q "$failText" "$logFile"; then
	exit 1
fi

exit 0

// File: sim/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Program words indexed by PC / 4
// Each emitStore call adds an SW and its expected address and data

function automatic logic [31:0] rTypeWord(
	input logic [5:0] funct,
	input int rs,
	input int rt,
	input int rd
);
	return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
endfunction

function automatic logic [31:0] iTypeWord(
	input logic [5:0] op,
	input int rs,
	input int rt,
	input logic [15:0] imm
);
	return {op, rs[4:0], rt[4:0], imm};
endfunction

function automatic logic [31:0] jTypeWord(input logic [5:0] op, input int target);
	return {op, target[25:0]};
endfunction

task automatic emitWord(input logic [31:0] word);
	progMem[progLen] = word;
	progLen++;
endtask

task automatic emitStore(input int rt, input logic [15:0] offset, input logic [31:0] value);
	emitWord(iTypeWord(6'h2B, 0, rt, offset)); // sw rt, offset(r0)
	expAddr.push_back({16'h0000, offset});
	expData.push_back(value);
endtask

task automatic emitPoison();
	emitWord(iTypeWord(6'h2B, 0, 1, poisonAddr[15:0]));
endtask

task automatic buildProgram();
	logic [31:0] linkValue;
	for (int i = 0; i < romWords; i++)
		progMem[i] = jTypeWord(6'h02, i); // Unused words trap in a self-jump
	progLen = 0;
	emitWord(iTypeWord(6'h0F, 0, 1, valA[31:16])); // lui r1
	emitWord(iTypeWord(6'h0D, 1, 1, valA[15:0])); // ori r1, r1 right behind
	emitWord(iTypeWord(6'h0F, 0, 2, valB[31:16]));
	emitWord(iTypeWord(6'h0D, 2, 2, valB[15:0]));
	emitWord(rTypeWord(6'h21, 1, 2, 3)); // addu
	emitStore(3, 16'h0100, valA + valB); // Store data from memory stage
	emitWord(rTypeWord(6'h23, 1, 2, 4)); // subu
	emitWord(32'h0000_0000);
	emitStore(4, 16'h0104, valA - valB); // From writeback stage
	emitWord(rTypeWord(6'h24, 1, 2, 5)); // and
	emitWord(rTypeWord(6'h25, 1, 2, 6)); // or
	emitWord(rTypeWord(6'h26, 1, 2, 7)); // xor
	emitWord(rTypeWord(6'h27, 1, 2, 8)); // nor
	emitWord(rTypeWord(6'h2A, 1, 2, 9)); // slt
	emitWord(rTypeWord(6'h2B, 1, 2, 10)); // sltu
	emitStore(5, 16'h0108, valA & valB);
	emitStore(6, 16'h010C, valA | valB);
	emitStore(7, 16'h0110, valA ^ valB);
	emitStore(8, 16'h0114, ~(valA | valB));
	emitStore(9, 16'h0118, {31'd0, $signed(valA) < $signed(valB)});
	emitStore(10, 16'h011C, {31'd0, valA < valB});
	emitWord(iTypeWord(6'h09, 1, 11, 16'hFFFB)); // addiu -5
	emitWord(iTypeWord(6'h0C, 1, 12, 16'hF0F0)); // andi
	emitWord(iTypeWord(6'h0E, 2, 13, 16'h5A5A)); // xori
	emitWord(iTypeWord(6'h0A, 2, 14, 16'h8000)); // slti -32768
	emitStore(11, 16'h0120, valA - 32'd5);
	emitStore(12, 16'h0124, valA & 32'h0000_F0F0);
	emitStore(13, 16'h0128, valB ^ 32'h0000_5A5A);
	emitStore(14, 16'h012C, {31'd0, $signed(valB) < $signed(32'hFFFF_8000)});
	stallAddr = (progLen + 2) * 4; // Fetch address held by the load-use bubble
	emitWord(iTypeWord(6'h23, 0, 15, 16'h0100)); // lw r15
	emitWord(rTypeWord(6'h21, 15, 1, 16)); // addu using r15 at once
	emitStore(16, 16'h0130, valA + valB + valA);
	emitWord(iTypeWord(6'h04, 1, 1, 16'h0002)); // Always-taken beq
	emitPoison();
	emitPoison();
	emitWord(iTypeWord(6'h05, 1, 1, 16'h0001)); // Never-taken bne
	emitStore(3, 16'h0134, valA + valB);
	emitWord(jTypeWord(6'h02, progLen + 2)); // j
	emitPoison();
	linkValue = progLen * 4 + 4;
	emitWord(jTypeWord(6'h03, progLen + 2)); // jal
	emitPoison();
	emitStore(31, 16'h0138, linkValue);
	selfJumpAddr = progLen * 4;
	emitWord(jTypeWord(6'h02, progLen)); // Final self-jump
endtask

`endif

// File: sim/tbMipsPipeline.sv
`timescale 1ns/1ns
`default_nettype none

module tbMipsPipeline;
	localparam logic [31:0] resetVector = 32'h0000_0000;
	localparam logic [31:0] poisonAddr = 32'h0000_03F0;
	localparam int romWords = 64;
	localparam int ramWords = 256;
	localparam int drainCycles = 8;

	logic Clk = 1'b0;
	logic rstN;
	logic [31:0] instr;
	logic [31:0] instrAddr, memAddr, memWrData, memRdData;
	logic memWrite, memRead;

	logic [31:0] progMem [romWords];
	logic [31:0] dataMem [ramWords];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] valA, valB, stallAddr, selfJumpAddr;
	logic [31:0] prevAddr = '0;
	logic prevRunning = 1'b0;
	logic reachedEnd = 1'b0;
	integer seed;
	int progLen, cycles, timeoutCycles, endErrors;
	int errors = 0;
	int storeCount = 0;
	int loadCount = 0;
	int holdCount = 0;

	`include "tbProgram.svh"

	mipsPipeline #(.resetVector(resetVector)) DUT (
		.Clk(Clk),
		.rstN(rstN),
		.instrAddr(instrAddr),
		.instr(instr),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memWrite(memWrite),
		.memRead(memRead),
		.memRdData(memRdData)
	);

	assign instr = progMem[instrAddr[7:2]];
	assign memRdData = dataMem[memAddr[9:2]];

	always @(posedge Clk) begin
		if (!rstN) begin
			for (int i = 0; i < ramWords; i++)
				dataMem[i] <= 32'hDA7A_0000 ^ (i * 4);
		end else if (memWrite)
			dataMem[memAddr[9:2]] <= memWrData;
	end

	initial begin
		forever #10 Clk = ~Clk;
	end

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic noteError(input string what);
		errors++;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	// Outputs are settled by the falling edge
	always @(negedge Clk) begin
		if (!rstN || !prevRunning) begin
			assert (!memWrite && !memRead)
				else noteError("memory strobe raised in or right after reset");
			checkWord("instrAddr", instrAddr, resetVector);
		end
		if (rstN && prevRunning && instrAddr == prevAddr) begin
			holdCount++;
			checkWord("instrAddr during stall", instrAddr, stallAddr);
		end
		if (rstN && memWrite) begin
			assert (memAddr != poisonAddr)
				else noteError("a flushed store reached the poison address");
			if (storeCount < expAddr.size()) begin
				checkWord("memAddr", memAddr, expAddr[storeCount]);
				checkWord("memWrData", memWrData, expData[storeCount]);
			end else
				noteError("store beyond the end of the expected list");
			storeCount++;
		end
		if (rstN && memRead) begin
			loadCount++;
			checkWord("memAddr on load", memAddr, expAddr[0]); // Load reads back the first store
		end
		if (rstN && instrAddr == selfJumpAddr)
			reachedEnd = 1'b1;
		prevAddr = instrAddr;
		prevRunning = rstN;
	end

	initial begin
		rstN = 1'b0;
		seed = 32'hd9f3_f102;
		cycles = 0;
		endErrors = 0;
		valA = $random(seed);
		valB = $random(seed);
		buildProgram();
		timeoutCycles = 8 * progLen + 50; // About 400 for this program
		repeat (2) @(posedge Clk);
		#2 rstN = 1'b1;
		while (!(reachedEnd && storeCount >= expAddr.size()) && cycles < timeoutCycles) begin
			@(posedge Clk);
			cycles++;
		end
		if (cycles >= timeoutCycles) begin
			endErrors++;
			$display("Timeout after %0d cycles, final jump or stores not reached", cycles);
		end else begin
			repeat (drainCycles) @(posedge Clk); // Catch any late stray store
		end
		assert (storeCount == expAddr.size()) else begin
			endErrors++;
			$display("Saw %0d stores, expected %0d", storeCount, expAddr.size());
		end
		assert (loadCount == 1) else begin
			endErrors++;
			$display("Saw %0d loads, expected exactly one", loadCount);
		end
		assert (holdCount == 1) else begin
			endErrors++;
			$display("PC held for %0d cycles instead of exactly one", holdCount);
		end
		$display("Errors: %0d, stores: %0d of %0d, stall cycles: %0d",
			errors + endErrors, storeCount, expAddr.size(), holdCount);
		if (errors + endErrors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
